// File: hw/videoBmp_config.svh
// frame geometry and buffer sizing for the BMP capture path, include in RTL and testbench
`ifndef VIDEO_BMP_CONFIG_SVH
`define VIDEO_BMP_CONFIG_SVH

// --------------------
// active picture
// --------------------
// pixels per line, gives 2 bytes of row padding
`define VIDEO_HACTIVE 10
// lines per frame
`define VIDEO_VACTIVE 6

// --------------------
// blanking
// --------------------
// idle cycles after each line, lets the writer drain a full row
`define VIDEO_HBLANK 24
// idle cycles from start of frame to first line
`define VIDEO_VBLANK 64

// pixel buffer between producer and writer
`define PIXEL_FIFO_DEPTH 16
// fixed BMP file plus info header length
`define BMP_HEADER_BYTES 54

`endif

// File: hw/videoPkg.sv
// pixel, coordinate and pattern types for the video producer side, imported by producer and FIFO
package videoPkg;

	// --------------------
	// pixel data
	// --------------------
	// one color channel
	typedef logic [7:0] color_t;
	// packed pixel, red [23:16], green [15:8], blue [7:0]
	typedef logic [23:0] pixel_t;
	// pixel or line position
	typedef logic [15:0] coord_t;

	// --------------------
	// pattern select
	// --------------------
	typedef logic [1:0] pattern_t;
	localparam pattern_t PAT_BARS     = 2'd0;
	localparam pattern_t PAT_GRADIENT = 2'd1;
	localparam pattern_t PAT_NOISE    = 2'd2;
	localparam pattern_t PAT_SOLID    = 2'd3;

	// noise generator state and seed
	typedef logic [15:0] lfsr_t;
	// galois feedback mask for taps 16, 14, 13, 11
	localparam lfsr_t LFSR_TAPS = 16'hB400;

	// producer scan states
	typedef enum logic [2:0] {
		GEN_IDLE,
		GEN_VBLANK,
		GEN_ACTIVE,
		GEN_HBLANK,
		GEN_FEND
	} genState_t;

endpackage

// File: hw/bmpPkg.sv
// byte stream types and BMP field constants for the writer side, imported by writer and top
package bmpPkg;

	// --------------------
	// stream data
	// --------------------
	// one output byte
	typedef logic [7:0] byte_t;
	// 32-bit size field, file size and image size
	typedef logic [31:0] byteCount_t;

	// --------------------
	// header constants
	// --------------------
	// signature characters "B" and "M"
	localparam byte_t BMP_SIG_B = 8'h42;
	localparam byte_t BMP_SIG_M = 8'h4D;
	// info header length
	localparam byteCount_t BMP_INFO_SIZE = 32'd40;
	// plane count, always one
	localparam byteCount_t BMP_PLANES = 32'd1;
	// bits per pixel, uncompressed rgb
	localparam byteCount_t BMP_BPP = 32'd24;
	// padding value between rows
	localparam byte_t BMP_PAD_BYTE = 8'h00;

	// --------------------
	// writer states
	// --------------------
	// header   54 fixed bytes
	// pixel    blue, green, red per popped pixel
	// pad      zero bytes up to a 4-byte row boundary
	// done     one cycle to raise save end
	typedef enum logic [2:0] {
		WR_IDLE,
		WR_HEADER,
		WR_PIXEL,
		WR_PAD,
		WR_DONE
	} writerState_t;

endpackage

// File: hw/videoPatternGen.sv
// test pattern frame scanner, one frame per accepted start request, feeds the pixel FIFO
`timescale 1ns/1ps
`include "videoBmp_config.svh"

module videoPatternGen (
	input  logic               iCLK,
	input  logic               iRST,
	input  logic               iFrameStart,
	input  videoPkg::pattern_t iPattern,
	input  videoPkg::lfsr_t    iSeed,
	input  logic               writerBusy,
	output logic               frameStart,
	output logic               frameEnd,
	output logic               pixelValid,
	output videoPkg::pixel_t   pixelData,
	output logic               oBusy
);
	import videoPkg::*;

	genState_t state;
	// hCnt doubles as pixel index and blanking counter
	coord_t hCnt;
	coord_t vCnt;
	pattern_t patReg;
	lfsr_t seedReg;
	lfsr_t lfsr;
	logic accept;
	logic [2:0] barIdx;
	color_t red;
	color_t green;
	color_t blue;

	// no new frame while scanning or while the writer drains
	assign accept = (state == GEN_IDLE) && iFrameStart && !writerBusy;
	assign oBusy = (state != GEN_IDLE) || writerBusy;

	assign pixelValid = (state == GEN_ACTIVE);
	assign frameEnd = (state == GEN_FEND);
	assign pixelData = {red, green, blue};

	// --------------------
	// scan control
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state <= GEN_IDLE;
			hCnt <= '0;
			vCnt <= '0;
			frameStart <= 1'b0;
		end
		else
		begin
			frameStart <= accept;
			case (state)
				GEN_IDLE:
				begin
					if (accept)
					begin
						state <= GEN_VBLANK;
						hCnt <= '0;
						vCnt <= '0;
					end
				end
				GEN_VBLANK:
				begin
					// frameStart cycle counts as first blank cycle
					if (hCnt == coord_t'(`VIDEO_VBLANK - 1))
					begin
						hCnt <= '0;
						state <= GEN_ACTIVE;
					end
					else
						hCnt <= hCnt + 1'b1;
				end
				GEN_ACTIVE:
				begin
					if (hCnt == coord_t'(`VIDEO_HACTIVE - 1))
					begin
						hCnt <= '0;
						state <= GEN_HBLANK;
					end
					else
						hCnt <= hCnt + 1'b1;
				end
				GEN_HBLANK:
				begin
					if (hCnt != coord_t'(`VIDEO_HBLANK - 1))
						hCnt <= hCnt + 1'b1;
					else if (vCnt == coord_t'(`VIDEO_VACTIVE - 1))
						state <= GEN_FEND;
					else
					begin
						hCnt <= '0;
						vCnt <= vCnt + 1'b1;
						state <= GEN_ACTIVE;
					end
				end
				// frame end strobe cycle
				GEN_FEND: state <= GEN_IDLE;
				default: state <= GEN_IDLE;
			endcase
		end
	end

	// --------------------
	// pattern source
	// --------------------
	// settings latched per frame, lfsr steps once per pixel
	always_ff @(posedge iCLK)
	begin
		if (accept)
		begin
			patReg <= iPattern;
			seedReg <= iSeed;
			lfsr <= (iSeed == '0) ? lfsr_t'(1) : iSeed;
		end
		else if (state == GEN_ACTIVE)
			lfsr <= lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
	end

	// eight equal bars across the line
	assign barIdx = 3'((32'(hCnt) * 8) / `VIDEO_HACTIVE);

	always_comb
	begin
		case (patReg)
			PAT_BARS:
			begin
				red = {8{barIdx[2]}};
				green = {8{barIdx[1]}};
				blue = {8{barIdx[0]}};
			end
			PAT_GRADIENT:
			begin
				red = color_t'(hCnt);
				green = color_t'(vCnt);
				blue = color_t'(hCnt ^ vCnt);
			end
			PAT_NOISE:
			begin
				red = lfsr[7:0];
				green = lfsr[15:8];
				blue = lfsr[7:0] ^ lfsr[15:8];
			end
			default:
			begin
				// solid color from the seed
				red = seedReg[7:0];
				green = seedReg[15:8];
				blue = 8'h80;
			end
		endcase
	end

endmodule

// File: hw/pixelFifo.sv
// synchronous pixel FIFO between producer and BMP writer, absorbs active line bursts
`timescale 1ns/1ps

module pixelFifo #(
	parameter int DEPTH = 16
) (
	input  logic             iCLK,
	input  logic             iRST,
	input  logic             push,
	input  videoPkg::pixel_t pushData,
	input  logic             pop,
	output videoPkg::pixel_t popData,
	output logic             empty,
	output logic             full
);
	import videoPkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	pixel_t mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic doPush;
	logic doPop;

	// requests past the limits are dropped
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	// head word, valid the cycle after its push
	assign popData = mem[rdPtr];

	// --------------------
	// storage
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	// --------------------
	// pointers and count
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			// simultaneous push and pop leave count alone
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: hw/bmpStreamWriter.sv
// BMP byte stream writer, emits header, BGR pixel bytes and row padding, then save end
`timescale 1ns/1ps
`include "videoBmp_config.svh"

module bmpStreamWriter (
	input  logic             iCLK,
	input  logic             iRST,
	input  logic             frameStart,
	input  logic             frameEnd,
	input  videoPkg::pixel_t fifoData,
	input  logic             fifoEmpty,
	output logic             fifoPop,
	output logic             writerBusy,
	output bmpPkg::byte_t    oByte,
	output logic             oByteValid,
	output logic             oSaveEnd
);
	import videoPkg::*;
	import bmpPkg::*;

	// --------------------
	// derived sizes
	// --------------------
	localparam int PAD_BYTES = (4 - ((3 * `VIDEO_HACTIVE) % 4)) % 4;
	localparam byteCount_t ROW_BYTES = byteCount_t'(3 * `VIDEO_HACTIVE + PAD_BYTES);
	localparam byteCount_t IMAGE_SIZE = ROW_BYTES * `VIDEO_VACTIVE;
	localparam byteCount_t FILE_SIZE = byteCount_t'(`BMP_HEADER_BYTES) + IMAGE_SIZE;

	writerState_t state;
	logic [5:0] hdrIdx;
	// 0 waits for a pixel, 1 green next, 2 red next
	logic [1:0] byteSel;
	logic [1:0] padCnt;
	coord_t pixCnt;
	coord_t rowCnt;
	pixel_t pixReg;
	logic endPending;
	logic endSeen;
	logic lastPix;
	logic lastRow;
	logic finalByte;

	// header byte by index, multi-byte fields little endian
	function automatic byte_t headerByte(input logic [5:0] idx);
		byteCount_t field;
		logic [5:0] base;
		logic [1:0] sel;
		field = '0;
		base = '0;
		// signature packed as a little endian field
		if (idx <= 6'd1)
			field = {16'h0000, BMP_SIG_M, BMP_SIG_B};
		else if (idx <= 6'd5)
		begin
			field = FILE_SIZE;
			base = 6'd2;
		end
		else if (idx >= 6'd10 && idx <= 6'd13)
		begin
			field = byteCount_t'(`BMP_HEADER_BYTES);
			base = 6'd10;
		end
		else if (idx >= 6'd14 && idx <= 6'd17)
		begin
			field = BMP_INFO_SIZE;
			base = 6'd14;
		end
		else if (idx >= 6'd18 && idx <= 6'd21)
		begin
			field = byteCount_t'(`VIDEO_HACTIVE);
			base = 6'd18;
		end
		else if (idx >= 6'd22 && idx <= 6'd25)
		begin
			field = byteCount_t'(`VIDEO_VACTIVE);
			base = 6'd22;
		end
		else if (idx >= 6'd26 && idx <= 6'd27)
		begin
			field = BMP_PLANES;
			base = 6'd26;
		end
		else if (idx >= 6'd28 && idx <= 6'd29)
		begin
			field = BMP_BPP;
			base = 6'd28;
		end
		// compression, resolution and color counts stay zero
		else if (idx >= 6'd34 && idx <= 6'd37)
		begin
			field = IMAGE_SIZE;
			base = 6'd34;
		end
		sel = 2'(idx - base);
		return field[{sel, 3'b000} +: 8];
	endfunction

	assign endSeen = endPending || frameEnd;
	assign lastPix = (pixCnt == coord_t'(`VIDEO_HACTIVE - 1));
	assign lastRow = (rowCnt == coord_t'(`VIDEO_VACTIVE - 1));
	// last byte of the frame, held back until frame end is known
	assign finalByte = lastRow && ((PAD_BYTES == 0) ?
		(state == WR_PIXEL && byteSel == 2'd2 && lastPix) :
		(state == WR_PAD && padCnt == 2'(PAD_BYTES - 1)));

	assign fifoPop = (state == WR_PIXEL) && (byteSel == 2'd0) && !fifoEmpty;
	assign writerBusy = (state != WR_IDLE) || frameStart;

	// --------------------
	// byte sequencer
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state <= WR_IDLE;
			oByteValid <= 1'b0;
			oSaveEnd <= 1'b0;
			endPending <= 1'b0;
			hdrIdx <= '0;
			byteSel <= '0;
			padCnt <= '0;
			pixCnt <= '0;
			rowCnt <= '0;
		end
		else
		begin
			oByteValid <= 1'b0;
			oSaveEnd <= 1'b0;
			if (frameEnd)
				endPending <= 1'b1;
			case (state)
				WR_IDLE:
				begin
					if (frameStart)
					begin
						oByte <= headerByte(6'd0);
						oByteValid <= 1'b1;
						hdrIdx <= 6'd1;
						byteSel <= '0;
						padCnt <= '0;
						pixCnt <= '0;
						rowCnt <= '0;
						endPending <= 1'b0;
						state <= WR_HEADER;
					end
				end
				WR_HEADER:
				begin
					oByte <= headerByte(hdrIdx);
					oByteValid <= 1'b1;
					if (hdrIdx == 6'(`BMP_HEADER_BYTES - 1))
						state <= WR_PIXEL;
					else
						hdrIdx <= hdrIdx + 1'b1;
				end
				WR_PIXEL:
				begin
					if (byteSel == 2'd0)
					begin
						// blue goes straight out of the FIFO head
						if (!fifoEmpty)
						begin
							pixReg <= fifoData;
							oByte <= fifoData[7:0];
							oByteValid <= 1'b1;
							byteSel <= 2'd1;
						end
					end
					else if (byteSel == 2'd1)
					begin
						oByte <= pixReg[15:8];
						oByteValid <= 1'b1;
						byteSel <= 2'd2;
					end
					else if (!(finalByte && !endSeen))
					begin
						oByte <= pixReg[23:16];
						oByteValid <= 1'b1;
						byteSel <= 2'd0;
						if (!lastPix)
							pixCnt <= pixCnt + 1'b1;
						else
						begin
							pixCnt <= '0;
							if (PAD_BYTES != 0)
								state <= WR_PAD;
							else
							begin
								rowCnt <= rowCnt + 1'b1;
								if (finalByte)
									state <= WR_DONE;
							end
						end
					end
				end
				WR_PAD:
				begin
					if (!(finalByte && !endSeen))
					begin
						oByte <= BMP_PAD_BYTE;
						oByteValid <= 1'b1;
						if (padCnt == 2'(PAD_BYTES - 1))
						begin
							padCnt <= '0;
							rowCnt <= rowCnt + 1'b1;
							state <= finalByte ? WR_DONE : WR_PIXEL;
						end
						else
							padCnt <= padCnt + 1'b1;
					end
				end
				// save end lands one cycle after the last byte
				WR_DONE:
				begin
					oSaveEnd <= 1'b1;
					endPending <= 1'b0;
					state <= WR_IDLE;
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

endmodule

// File: hw/videoBmpTop.sv
// capture path top level, pattern producer into pixel FIFO into BMP byte stream writer
`timescale 1ns/1ps
`include "videoBmp_config.svh"

module videoBmpTop (
	input  logic               iCLK,
	input  logic               iRST,
	input  logic               iFrameStart,
	input  videoPkg::pattern_t iPattern,
	input  videoPkg::lfsr_t    iSeed,
	output bmpPkg::byte_t      oByte,
	output logic               oByteValid,
	output logic               oSaveEnd,
	output logic               oBusy
);
	import videoPkg::*;

	// --------------------
	// internal links
	// --------------------
	logic frameStart;
	logic frameEnd;
	logic pixelValid;
	pixel_t pixelData;
	pixel_t fifoData;
	logic fifoEmpty;
	logic fifoPop;
	logic writerBusy;

	videoPatternGen videoPatternGen_inst (
		.iCLK        (iCLK),
		.iRST        (iRST),
		.iFrameStart (iFrameStart),
		.iPattern    (iPattern),
		.iSeed       (iSeed),
		.writerBusy  (writerBusy),
		.frameStart  (frameStart),
		.frameEnd    (frameEnd),
		.pixelValid  (pixelValid),
		.pixelData   (pixelData),
		.oBusy       (oBusy)
	);

	// full left open, blanking keeps occupancy below depth
	pixelFifo #(
		.DEPTH (`PIXEL_FIFO_DEPTH)
	) pixelFifo_inst (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.push     (pixelValid),
		.pushData (pixelData),
		.pop      (fifoPop),
		.popData  (fifoData),
		.empty    (fifoEmpty),
		.full     ()
	);

	bmpStreamWriter bmpStreamWriter_inst (
		.iCLK       (iCLK),
		.iRST       (iRST),
		.frameStart (frameStart),
		.frameEnd   (frameEnd),
		.fifoData   (fifoData),
		.fifoEmpty  (fifoEmpty),
		.fifoPop    (fifoPop),
		.writerBusy (writerBusy),
		.oByte      (oByte),
		.oByteValid (oByteValid),
		.oSaveEnd   (oSaveEnd)
	);

endmodule

// File: dv/videoBmp_assertions.sv
// concurrent checks on FIFO occupancy, writer strobes and reset state, attached to FIFO and writer by bind
`timescale 1ns/1ps

module videoBmp_assertions #(
	// 1 when attached to the FIFO, 0 when attached to the writer
	parameter bit FIFO_SIDE = 1'b0
) (
	input logic iCLK,
	input logic iRST,
	input logic push,
	input logic full,
	input logic empty,
	input logic byteValid,
	input logic saveEnd,
	input logic busy
);

	if (FIFO_SIDE)
	begin : fifoProps
		// producer never outruns the FIFO
		noPushWhenFull: assert property (@(posedge iCLK) disable iff (iRST) !(push && full))
			else $error("pixel pushed into a full FIFO");

		// buffer drained by reset
		emptyAfterReset: assert property (@(posedge iCLK) iRST |=> empty)
			else $error("FIFO not empty after reset");
	end
	else
	begin : writerProps
		// byte strobe and frame done are exclusive
		noByteWithSaveEnd: assert property (@(posedge iCLK) disable iff (iRST)
			!(byteValid && saveEnd))
			else $error("byte valid and save end high together");

		saveEndSingle: assert property (@(posedge iCLK) disable iff (iRST) saveEnd |=> !saveEnd)
			else $error("save end held longer than one cycle");

		// everything quiet right after a reset edge
		resetQuiet: assert property (@(posedge iCLK)
			iRST |=> (!byteValid && !saveEnd && !busy))
			else $error("strobe or busy high after reset");
	end

endmodule

// --------------------
// attachments
// --------------------
// FIFO side, writer inputs tied to idle levels
bind pixelFifo videoBmp_assertions #(
	.FIFO_SIDE (1'b1)
) fifoChecks (
	.iCLK      (iCLK),
	.iRST      (iRST),
	.push      (push),
	.full      (full),
	.empty     (empty),
	.byteValid (1'b0),
	.saveEnd   (1'b0),
	.busy      (1'b0)
);

// writer side, FIFO inputs tied to idle levels
bind bmpStreamWriter videoBmp_assertions #(
	.FIFO_SIDE (1'b0)
) writerChecks (
	.iCLK      (iCLK),
	.iRST      (iRST),
	.push      (1'b0),
	.full      (1'b0),
	.empty     (1'b1),
	.byteValid (oByteValid),
	.saveEnd   (oSaveEnd),
	.busy      (writerBusy)
);

// File: dv/videoBmpTb.sv
// self-checking testbench for the BMP capture path, random frame requests checked against a byte model
`timescale 1ns/1ps
`include "videoBmp_config.svh"

module videoBmpTb;
	import videoPkg::*;
	import bmpPkg::*;

	// --------------------
	// run length
	// --------------------
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int FRAME_COUNT = 12;
	localparam int MAX_GAP = 20;
	// zero bytes closing each row up to a multiple of four
	localparam int PAD_BYTES = (4 - ((3 * `VIDEO_HACTIVE) % 4)) % 4;
	localparam int IMAGE_BYTES = (3 * `VIDEO_HACTIVE + PAD_BYTES) * `VIDEO_VACTIVE;
	localparam int FRAME_BYTES = `BMP_HEADER_BYTES + IMAGE_BYTES;
	// scan, start latency and one row of drain, worst case per frame
	localparam int FRAME_CYCLES = 4 + `VIDEO_VBLANK
		+ `VIDEO_VACTIVE * (`VIDEO_HACTIVE + `VIDEO_HBLANK) + 3 * `VIDEO_HACTIVE + PAD_BYTES;
	localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + FRAME_COUNT * (FRAME_CYCLES + MAX_GAP));
	// quiet stretch after the last frame
	localparam int TAIL_CYCLES = 32;

	logic iCLK;
	logic iRST;
	logic iFrameStart;
	pattern_t iPattern;
	lfsr_t iSeed;
	byte_t oByte;
	logic oByteValid;
	logic oSaveEnd;
	logic oBusy;

	// expected stream of the frame in flight
	byte_t expQ[$];
	int cycleCnt = 0;
	int startCycle = 0;
	int frameIdx = 0;
	int frameBytes = 0;
	int totalBytes = 0;
	int lastByteCycle = 0;
	int saveEndCount = 0;
	logic saveEndPrev = 1'b0;
	pattern_t pattern;
	lfsr_t seed;
	int gap;

	videoBmpTop videoBmpTop_inst (
		.iCLK        (iCLK),
		.iRST        (iRST),
		.iFrameStart (iFrameStart),
		.iPattern    (iPattern),
		.iSeed       (iSeed),
		.oByte       (oByte),
		.oByteValid  (oByteValid),
		.oSaveEnd    (oSaveEnd),
		.oBusy       (oBusy)
	);

	initial
	begin
		iCLK = 1'b0;
		forever
			#(CLK_PERIOD / 2) iCLK = ~iCLK;
	end

	// edge count, read only on falling edges
	always @(posedge iCLK)
		cycleCnt <= cycleCnt + 1;

	// --------------------
	// checks
	// --------------------
	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic compareByte(input string testName, input byte_t expected, input byte_t actual);
		if (actual !== expected)
			abortRun($sformatf("Error %s: expected 0x%02h, actual 0x%02h",
				testName, expected, actual));
	endtask

	task automatic compareCount(input string testName, input byteCount_t expected,
		input byteCount_t actual);
		if (actual !== expected)
			abortRun($sformatf("Error %s: expected %0d, actual %0d", testName, expected, actual));
	endtask

	task automatic compareFlag(input string testName, input logic expected, input logic actual);
		if (actual !== expected)
			abortRun($sformatf("Error %s: expected %b, actual %b", testName, expected, actual));
	endtask

	// nothing may come out between frames
	task automatic checkIdle();
		compareFlag("byte valid while idle", 1'b0, oByteValid);
		compareFlag("save end while idle", 1'b0, oSaveEnd);
		compareFlag("busy while idle", 1'b0, oBusy);
	endtask

	// --------------------
	// reference model
	// --------------------
	// little endian field of nBytes bytes
	task automatic pushField(input byteCount_t value, input int nBytes);
		for (int i = 0; i < nBytes; i++)
			expQ.push_back(byte_t'(value >> (8 * i)));
	endtask

	task automatic buildFrame(input pattern_t pat, input lfsr_t frameSeed);
		lfsr_t noise;
		int bar;
		color_t r;
		color_t g;
		color_t b;
		// file header, signature BM
		expQ.push_back(8'h42);
		expQ.push_back(8'h4D);
		pushField(byteCount_t'(FRAME_BYTES), 4);
		pushField('0, 4);
		pushField(byteCount_t'(`BMP_HEADER_BYTES), 4);
		// info header
		pushField(32'd40, 4);
		pushField(byteCount_t'(`VIDEO_HACTIVE), 4);
		pushField(byteCount_t'(`VIDEO_VACTIVE), 4);
		pushField(32'd1, 2);
		pushField(32'd24, 2);
		pushField('0, 4);
		pushField(byteCount_t'(IMAGE_BYTES), 4);
		// resolution and color counts all zero
		pushField('0, 16);
		noise = (frameSeed == '0) ? 16'd1 : frameSeed;
		for (int y = 0; y < `VIDEO_VACTIVE; y++)
		begin
			for (int x = 0; x < `VIDEO_HACTIVE; x++)
			begin
				case (pat)
					PAT_BARS:
					begin
						bar = x * 8 / `VIDEO_HACTIVE;
						r = (bar & 4) ? 8'hFF : 8'h00;
						g = (bar & 2) ? 8'hFF : 8'h00;
						b = (bar & 1) ? 8'hFF : 8'h00;
					end
					PAT_GRADIENT:
					begin
						r = color_t'(x);
						g = color_t'(y);
						b = color_t'(x ^ y);
					end
					PAT_NOISE:
					begin
						r = noise[7:0];
						g = noise[15:8];
						b = noise[7:0] ^ noise[15:8];
					end
					default:
					begin
						r = frameSeed[7:0];
						g = frameSeed[15:8];
						b = 8'h80;
					end
				endcase
				// right shift galois step, taps 16 14 13 11 give mask bits 15 13 12 10
				noise = noise[0] ? ((noise >> 1) ^ 16'hB400) : (noise >> 1);
				expQ.push_back(b);
				expQ.push_back(g);
				expQ.push_back(r);
			end
			pushField('0, PAD_BYTES);
		end
	endtask

	// --------------------
	// output monitor
	// --------------------
	always @(negedge iCLK)
	begin
		if (!iRST)
		begin
			compareFlag("byte valid with save end", 1'b0, oByteValid && oSaveEnd);
			compareFlag("fifo push while full", 1'b0,
				videoBmpTop_inst.pixelFifo_inst.push && videoBmpTop_inst.pixelFifo_inst.full);
			if (oByteValid)
			begin
				if (expQ.size() == 0)
					abortRun("a byte came out with no frame outstanding");
				else
				begin
					// start driven one edge before acceptance
					if (frameBytes == 0)
						compareCount("first byte latency", byteCount_t'(startCycle + 2),
							byteCount_t'(cycleCnt));
					compareByte($sformatf("frame %0d byte %0d", frameIdx, frameBytes),
						expQ.pop_front(), oByte);
					frameBytes++;
					totalBytes++;
					lastByteCycle = cycleCnt;
				end
			end
			if (oSaveEnd)
			begin
				compareFlag("save end width", 1'b0, saveEndPrev);
				compareCount("bytes per frame", byteCount_t'(FRAME_BYTES), byteCount_t'(frameBytes));
				compareCount("save end after last byte", byteCount_t'(lastByteCycle + 1),
					byteCount_t'(cycleCnt));
				compareFlag("busy at save end", 1'b0, oBusy);
				saveEndCount++;
				frameBytes = 0;
			end
			saveEndPrev = oSaveEnd;
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abortRun("watchdog expired before all frames were saved");
	end

	// --------------------
	// stimulus
	// --------------------
	initial
	begin
		void'($urandom(37234));
		iRST = 1'b1;
		iFrameStart = 1'b0;
		iPattern = '0;
		iSeed = '0;
		repeat (RESET_CYCLES)
		begin
			@(posedge iCLK);
			@(negedge iCLK);
			checkIdle();
		end
		iRST = 1'b0;
		for (int f = 0; f < FRAME_COUNT; f++)
		begin
			gap = $urandom_range(MAX_GAP, 0);
			repeat (gap)
			begin
				@(negedge iCLK);
				checkIdle();
			end
			@(negedge iCLK);
			checkIdle();
			// first four frames walk all patterns, frame 4 hits the zero seed
			pattern = (f < 4) ? pattern_t'(f) : pattern_t'($urandom);
			seed = lfsr_t'($urandom);
			if (f == 4)
			begin
				pattern = PAT_NOISE;
				seed = '0;
			end
			frameIdx = f;
			buildFrame(pattern, seed);
			startCycle = cycleCnt;
			iFrameStart = 1'b1;
			iPattern = pattern;
			iSeed = seed;
			@(negedge iCLK);
			iFrameStart = 1'b0;
			// stray requests while busy must be ignored
			while (!oSaveEnd)
			begin
				@(negedge iCLK);
				iFrameStart = 1'b0;
				// busy covers the whole frame up to save end
				if (!oSaveEnd)
					compareFlag("busy during frame", 1'b1, oBusy);
				if (oBusy && ($urandom_range(15, 0) == 0))
				begin
					iFrameStart = 1'b1;
					iPattern = pattern_t'($urandom);
					iSeed = lfsr_t'($urandom);
				end
			end
		end
		repeat (TAIL_CYCLES)
		begin
			@(negedge iCLK);
			checkIdle();
		end
		compareCount("frames saved", byteCount_t'(FRAME_COUNT), byteCount_t'(saveEndCount));
		compareCount("total bytes", byteCount_t'(FRAME_COUNT * FRAME_BYTES),
			byteCount_t'(totalBytes));
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: src.f
+incdir+hw
hw/videoPkg.sv
hw/bmpPkg.sv
hw/videoPatternGen.sv
hw/pixelFifo.sv
hw/bmpStreamWriter.sv
hw/videoBmpTop.sv
dv/videoBmp_assertions.sv
dv/videoBmpTb.sv

// File: run.sh
#!/bin/sh
# compile the capture path testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module videoBmpTb -o videoBmpSim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/videoBmpSim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

echo "simulation exited cleanly"
exit 0
